//--- rtl/ooo_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes, types and records for the out-of-order completion engine.
// Modules take these through a wildcard import in their body, and refer
// to them by scoped name in their port lists.
////////////////////////////////////////////////////////////////////////////

package ooo_pkg;

  // Core sizes
  localparam int NUM_LANES   = 4;
  localparam int ROB_SZ      = 8;
  localparam int DATA_W      = 16;
  localparam int SEQ_W       = 8;
  localparam int QUEUE_DEPTH = 4;

  // Index types, sized to match ROB_SZ and NUM_LANES
  typedef logic [$clog2(ROB_SZ)-1:0]    rob_idx_t;
  typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_BRANCH
  } op_kind_t;

  // Instruction as it enters; lat encodes 1 to 4 cycles as 0 to 3
  typedef struct packed {
    op_kind_t          kind;
    logic [1:0]        lat;
    logic [SEQ_W-1:0]  seq;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              pred_taken;
  } instr_t;

  // Record that leaves through the commit queue
  typedef struct packed {
    logic [SEQ_W-1:0]  seq;
    op_kind_t          kind;
    logic [DATA_W-1:0] result;
    logic              taken;
    logic              mispredict;
  } commit_t;

  // One reorder-buffer slot
  typedef struct packed {
    logic              valid;
    logic              complete;
    logic [SEQ_W-1:0]  seq;
    op_kind_t          kind;
    logic              pred_taken;
    logic [DATA_W-1:0] result;
    logic              taken;
  } rob_entry_t;

endpackage

//--- rtl/sync_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous circular queue with valid/ready on both sides.
// The payload type is a parameter, so one module serves both the
// instruction queue and the commit queue. Flush drops all contents.
////////////////////////////////////////////////////////////////////////////

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  payload_t                     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         push_fire;
  logic                         pop_fire;

  // A full queue still takes a push when the head leaves the same cycle
  assign push_ready = !flush && ((count != DEPTH) || pop_ready);
  assign pop_valid  = (count != 0);
  assign pop_data   = mem[rd_ptr];

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // Pointers and occupancy
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire)
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop_fire)
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      // Net change of one at most
      if (push_fire && !pop_fire)
        count <= count + 1'b1;
      else if (pop_fire && !push_fire)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (push_fire)
      mem[wr_ptr] <= push_data;
  end

endmodule

//--- rtl/dispatch.sv
////////////////////////////////////////////////////////////////////////////
// Dispatch: takes the oldest waiting instruction, allocates a ROB entry
// and issues it to the lowest-numbered idle lane, all in one cycle.
////////////////////////////////////////////////////////////////////////////

module dispatch (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             flush,
  // Input queue side
  input  logic                             pop_valid,
  input  ooo_pkg::instr_t                  pop_data,
  output logic                             pop_ready,
  // ROB allocation
  input  logic                             rob_full,
  input  ooo_pkg::rob_idx_t                alloc_idx,
  output logic                             alloc_valid,
  output logic [ooo_pkg::SEQ_W-1:0]        alloc_seq,
  output ooo_pkg::op_kind_t                alloc_kind,
  output logic                             alloc_pred,
  // Lane issue
  input  logic [ooo_pkg::NUM_LANES-1:0]    lane_busy,
  output logic [ooo_pkg::NUM_LANES-1:0]    issue_valid,
  output ooo_pkg::instr_t                  issue_instr,
  output ooo_pkg::rob_idx_t                issue_idx
);

  import ooo_pkg::*;

  lane_idx_t   sel_lane;
  logic        any_idle;
  logic        fire;
  logic [15:0] issued_count;

  // Priority encoder, lane 0 wins. Scan from the top so
  // the lowest idle lane is the last one written
  always_comb begin
    sel_lane = '0;
    any_idle = 1'b0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (!lane_busy[i]) begin
        sel_lane = lane_idx_t'(i);
        any_idle = 1'b1;
      end
    end
  end

  // Issue needs an instruction, a ROB slot, a lane and no squash
  assign fire      = pop_valid && !rob_full && any_idle && !flush;
  assign pop_ready = fire;

  // ROB gets the fields that retire will need
  assign alloc_valid = fire;
  assign alloc_seq   = pop_data.seq;
  assign alloc_kind  = pop_data.kind;
  assign alloc_pred  = pop_data.pred_taken;

  // The instruction and its ROB tag go to all lanes,
  // only the selected one sees issue_valid
  assign issue_instr = pop_data;
  assign issue_idx   = alloc_idx;

  always_comb begin
    issue_valid = '0;
    if (fire)
      issue_valid[sel_lane] = 1'b1;
  end

  // Running count of issued instructions, wraps freely
  always_ff @(posedge clock) begin
    if (reset)
      issued_count <= '0;
    else if (fire)
      issued_count <= issued_count + 1'b1;
  end

endmodule

//--- rtl/exec_lane.sv
////////////////////////////////////////////////////////////////////////////
// One execution lane. Holds a single operation, counts down its latency
// and presents the result for one cycle. Flush drops the operation.
////////////////////////////////////////////////////////////////////////////

module exec_lane (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       issue_valid,
  input  ooo_pkg::instr_t            issue_instr,
  input  ooo_pkg::rob_idx_t          issue_idx,
  output logic                       busy,
  output logic                       done_valid,
  output ooo_pkg::rob_idx_t          done_idx,
  output logic [ooo_pkg::DATA_W-1:0] done_result,
  output logic                       done_taken
);

  import ooo_pkg::*;

  instr_t     op;
  rob_idx_t   op_idx;
  logic [2:0] cnt;

  // Control. cnt starts at the latency, 1 to 4, and
  // the lane reports once it reaches zero
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (issue_valid) begin
      busy <= 1'b1;
      cnt  <= {1'b0, issue_instr.lat} + 3'd1;
    end else if (busy) begin
      if (cnt == 3'd0)
        busy <= 1'b0;
      else
        cnt <= cnt - 3'd1;
    end
  end

  // Operation payload
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      op     <= issue_instr;
      op_idx <= issue_idx;
    end
  end

  // Completion lasts exactly the one cycle with cnt at zero
  assign done_valid = busy && (cnt == 3'd0);
  assign done_idx   = op_idx;

  // Branches produce no data, only the outcome
  always_comb begin
    case (op.kind)
      OP_ADD:  done_result = op.a + op.b;
      OP_SUB:  done_result = op.a - op.b;
      default: done_result = '0;
    endcase
  end

  assign done_taken = (op.kind == OP_BRANCH) && (op.a == op.b);

endmodule

//--- rtl/rob.sv
////////////////////////////////////////////////////////////////////////////
// Reorder buffer. Circular store of in-flight instructions with head
// (oldest) and tail (next allocation). Dispatch allocates at the tail,
// lanes mark entries complete in any order, retire drains the head.
////////////////////////////////////////////////////////////////////////////

module rob (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              flush,
  // Allocation from dispatch
  input  logic                                              alloc_valid,
  input  logic [ooo_pkg::SEQ_W-1:0]                         alloc_seq,
  input  ooo_pkg::op_kind_t                                 alloc_kind,
  input  logic                                              alloc_pred,
  output ooo_pkg::rob_idx_t                                 alloc_idx,
  output logic                                              rob_full,
  // One completion port per lane
  input  logic [ooo_pkg::NUM_LANES-1:0]                     done_valid,
  input  ooo_pkg::rob_idx_t [ooo_pkg::NUM_LANES-1:0]        done_idx,
  input  logic [ooo_pkg::NUM_LANES-1:0][ooo_pkg::DATA_W-1:0] done_result,
  input  logic [ooo_pkg::NUM_LANES-1:0]                     done_taken,
  // Retire side
  output logic                                              head_valid,
  output ooo_pkg::rob_entry_t                               head_entry,
  input  logic                                              retire_pop
);

  import ooo_pkg::*;

  rob_entry_t                  entries [ROB_SZ];
  rob_idx_t                    head;
  rob_idx_t                    tail;
  logic [$clog2(ROB_SZ+1)-1:0] count;

  ////////////////////////////////////////////////////////////////////////////
  // Status outputs
  ////////////////////////////////////////////////////////////////////////////

  assign alloc_idx  = tail;
  assign rob_full   = (count == ROB_SZ);
  assign head_entry = entries[head];
  // Only a finished head entry may leave
  assign head_valid = entries[head].valid && entries[head].complete;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // Flush comes from the head entry, so restart just past it
      head  <= head + 1'b1;
      tail  <= head + 1'b1;
      count <= '0;
    end else begin
      if (alloc_valid)
        tail <= tail + 1'b1;
      if (retire_pop)
        head <= head + 1'b1;
      if (alloc_valid && !retire_pop)
        count <= count + 1'b1;
      else if (retire_pop && !alloc_valid)
        count <= count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Entry array
  ////////////////////////////////////////////////////////////////////////////

  // Alloc, completion and retire never touch the same slot in one
  // cycle. Tail is free, completions target issued entries, and
  // the head is already complete when it is popped
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      for (int i = 0; i < ROB_SZ; i++) begin
        entries[i].valid    <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      if (alloc_valid) begin
        entries[tail].valid      <= 1'b1;
        entries[tail].complete   <= 1'b0;
        entries[tail].seq        <= alloc_seq;
        entries[tail].kind       <= alloc_kind;
        entries[tail].pred_taken <= alloc_pred;
        entries[tail].result     <= '0;
        entries[tail].taken      <= 1'b0;
      end
      // Completions in any order, one per lane
      for (int l = 0; l < NUM_LANES; l++) begin
        if (done_valid[l]) begin
          entries[done_idx[l]].complete <= 1'b1;
          entries[done_idx[l]].result   <= done_result[l];
          entries[done_idx[l]].taken    <= done_taken[l];
        end
      end
      if (retire_pop)
        entries[head].valid <= 1'b0;
    end
  end

endmodule

//--- rtl/retire.sv
////////////////////////////////////////////////////////////////////////////
// Retire: moves the completed head entry into the commit queue in
// program order and raises flush when a mispredicted branch commits.
////////////////////////////////////////////////////////////////////////////

module retire (
  input  logic                clock,
  input  logic                reset,
  input  logic                head_valid,
  input  ooo_pkg::rob_entry_t head_entry,
  output logic                retire_pop,
  output logic                push_valid,
  input  logic                push_ready,
  output ooo_pkg::commit_t    push_data,
  output logic                flush
);

  import ooo_pkg::*;

  logic        mispredict;
  logic [15:0] retired_count;
  logic [15:0] mispred_count;

  // Taken outcome disagrees with the prediction
  assign mispredict = (head_entry.kind == OP_BRANCH) &&
                      (head_entry.taken != head_entry.pred_taken);

  // Commit record straight from the head entry
  always_comb begin
    push_data.seq        = head_entry.seq;
    push_data.kind       = head_entry.kind;
    push_data.result     = head_entry.result;
    push_data.taken      = head_entry.taken;
    push_data.mispredict = mispredict;
  end

  assign push_valid = head_valid;

  // Head advances only on an accepted push
  assign retire_pop = head_valid && push_ready;

  // Everything younger than this branch is on the wrong path
  assign flush = retire_pop && mispredict;

  // Statistics, internal only
  always_ff @(posedge clock) begin
    if (reset) begin
      retired_count <= '0;
      mispred_count <= '0;
    end else begin
      if (retire_pop)
        retired_count <= retired_count + 1'b1;
      if (flush)
        mispred_count <= mispred_count + 1'b1;
    end
  end

endmodule

//--- rtl/ooo_core_top.sv
////////////////////////////////////////////////////////////////////////////
// Top of the completion engine. Input queue, dispatch, four execution
// lanes, reorder buffer, retire and commit queue, wired in a loop of
// valid/ready handshakes. redirect marks a mispredict recovery.
////////////////////////////////////////////////////////////////////////////

module ooo_core_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  ooo_pkg::instr_t  in_instr,
  output logic             commit_valid,
  input  logic             commit_ready,
  output ooo_pkg::commit_t commit_rec,
  output logic             redirect
);

  import ooo_pkg::*;

  // Input queue to dispatch
  logic     pop_valid;
  logic     pop_ready;
  instr_t   pop_data;

  // Dispatch and ROB
  logic             alloc_valid;
  logic [SEQ_W-1:0] alloc_seq;
  op_kind_t         alloc_kind;
  logic             alloc_pred;
  rob_idx_t         alloc_idx;
  logic             rob_full;

  // Dispatch and lanes
  logic [NUM_LANES-1:0] lane_busy;
  logic [NUM_LANES-1:0] issue_valid;
  instr_t               issue_instr;
  rob_idx_t             issue_idx;

  // Lanes to ROB
  logic [NUM_LANES-1:0]             done_valid;
  rob_idx_t [NUM_LANES-1:0]         done_idx;
  logic [NUM_LANES-1:0][DATA_W-1:0] done_result;
  logic [NUM_LANES-1:0]             done_taken;

  // ROB, retire and commit queue
  logic       head_valid;
  rob_entry_t head_entry;
  logic       retire_pop;
  logic       push_valid;
  logic       push_ready;
  commit_t    push_data;
  logic       flush;

  assign redirect = flush;

  sync_fifo #(.payload_t(instr_t), .DEPTH(QUEUE_DEPTH)) in_queue (
    .clock, .reset, .flush,
    .push_valid(in_valid), .push_ready(in_ready), .push_data(in_instr),
    .pop_valid, .pop_ready, .pop_data
  );

  dispatch dispatch_i (
    .clock, .reset, .flush,
    .pop_valid, .pop_data, .pop_ready,
    .rob_full, .alloc_idx, .alloc_valid, .alloc_seq, .alloc_kind, .alloc_pred,
    .lane_busy, .issue_valid, .issue_instr, .issue_idx
  );

  // Identical lanes, each with its own completion port
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exec_lane exec_lane_i (
      .clock, .reset, .flush,
      .issue_valid(issue_valid[g]), .issue_instr, .issue_idx,
      .busy(lane_busy[g]), .done_valid(done_valid[g]), .done_idx(done_idx[g]),
      .done_result(done_result[g]), .done_taken(done_taken[g])
    );
  end

  rob rob_i (
    .clock, .reset, .flush,
    .alloc_valid, .alloc_seq, .alloc_kind, .alloc_pred, .alloc_idx, .rob_full,
    .done_valid, .done_idx, .done_result, .done_taken,
    .head_valid, .head_entry, .retire_pop
  );

  retire retire_i (
    .clock, .reset, .head_valid, .head_entry, .retire_pop,
    .push_valid, .push_ready, .push_data, .flush
  );

  // Committed records are never squashed
  sync_fifo #(.payload_t(commit_t), .DEPTH(QUEUE_DEPTH)) commit_queue (
    .clock, .reset, .flush(1'b0),
    .push_valid, .push_ready, .push_data,
    .pop_valid(commit_valid), .pop_ready(commit_ready), .pop_data(commit_rec)
  );

endmodule

//--- tb/ooo_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the completion engine. Drives instructions on the falling
// edge, keeps a model queue of expected commit records and checks every
// commit, redirect and hold condition with assertions on the rising edge.
////////////////////////////////////////////////////////////////////////////

module ooo_core_tb;

  import ooo_pkg::*;

  logic    clock;
  logic    reset;
  logic    in_valid;
  logic    in_ready;
  instr_t  in_instr;
  logic    commit_valid;
  logic    commit_ready;
  commit_t commit_rec;
  logic    redirect;

  // Stimulus and model state
  logic [31:0]      lfsr = 32'hcaff;
  logic [SEQ_W-1:0] seq_ctr = '0;
  int               ready_mode = 1;
  int               errors = 0;
  int               test_errors = 0;
  int               redirects = 0;
  int               dropped = 0;
  commit_t          exp_q[$];
  commit_t          exp_rec;
  commit_t          rec_prev;
  int               fence = 0;
  int               idx;
  bit               hold_prev = 0;
  bit               redirect_prev = 0;

  ooo_core_top ooo_core_top_i (
    .clock, .reset, .in_valid, .in_ready, .in_instr,
    .commit_valid, .commit_ready, .commit_rec, .redirect
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Hard stop in case a bounded wait is never reached
  initial begin
    repeat (200000) @(posedge clock);
    $display("ERROR t=%0t global timeout, simulation did not finish", $time);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and instruction building
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'ha3000000;
    return s >> 1;
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic instr_t make_instr(input op_kind_t k, input logic [1:0] lat,
                                        input logic [DATA_W-1:0] a,
                                        input logic [DATA_W-1:0] b, input logic pred);
    instr_t ins;
    ins            = '0;
    ins.kind       = k;
    ins.lat        = lat;
    ins.a          = a;
    ins.b          = b;
    ins.pred_taken = pred;
    return ins;
  endfunction

  function instr_t random_instr();
    logic [1:0]        r;
    op_kind_t          k;
    logic [1:0]        lat;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    r   = rand_bits(2);
    k   = (r == 2'd0) ? OP_ADD : (r == 2'd1) ? OP_SUB : OP_BRANCH;
    lat = rand_bits(2);
    a   = rand_bits(DATA_W);
    b   = rand_bits(DATA_W);
    // Equal operands often enough to see taken branches
    if (k == OP_BRANCH && rand_bits(1))
      b = a;
    return make_instr(k, lat, a, b, rand_bits(1));
  endfunction

  // Expected commit record from the lane and retire rules
  function automatic commit_t expected_commit(input instr_t ins);
    commit_t r;
    r.seq  = ins.seq;
    r.kind = ins.kind;
    case (ins.kind)
      OP_ADD:  r.result = ins.a + ins.b;
      OP_SUB:  r.result = ins.a - ins.b;
      default: r.result = '0;
    endcase
    r.taken      = (ins.kind == OP_BRANCH) && (ins.a == ins.b);
    r.mispredict = (ins.kind == OP_BRANCH) && (r.taken != ins.pred_taken);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Model and checks on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      hold_prev     = 1'b0;
      redirect_prev = 1'b0;
    end else begin
      // A stalled record stays put
      if (hold_prev) begin
        assert (commit_valid) else begin
          errors++;
          $display("ERROR t=%0t commit_valid expected 1 got %0b", $time, commit_valid);
        end
        assert (commit_rec == rec_prev) else begin
          errors++;
          $display("ERROR t=%0t commit_rec expected %h got %h", $time, rec_prev, commit_rec);
        end
      end
      if (commit_valid && commit_ready) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("ERROR t=%0t a record with seq %0d committed with nothing outstanding",
                   $time, commit_rec.seq);
        end
        if (exp_q.size() != 0) begin
          exp_rec = exp_q.pop_front();
          assert (!exp_rec.mispredict || fence > 0) else begin
            errors++;
            $display("ERROR t=%0t mispredicted branch seq %0d committed without redirect",
                     $time, exp_rec.seq);
          end
          if (fence > 0)
            fence--;
          assert (commit_rec == exp_rec) else begin
            errors++;
            $display("ERROR t=%0t commit_rec expected %h got %h", $time, exp_rec, commit_rec);
          end
        end
      end
      if (redirect) begin
        redirects++;
        assert (!redirect_prev) else begin
          errors++;
          $display("ERROR t=%0t redirect stayed high for more than one cycle", $time);
        end
        // The oldest live mispredicted branch is the one retiring
        idx = -1;
        for (int i = fence; i < exp_q.size(); i++)
          if (idx < 0 && exp_q[i].mispredict)
            idx = i;
        assert (idx >= 0) else begin
          errors++;
          $display("ERROR t=%0t redirect with no mispredicted branch outstanding", $time);
        end
        if (idx >= 0) begin
          // Everything behind the branch is on the wrong path
          dropped += exp_q.size() - idx - 1;
          while (exp_q.size() > idx + 1)
            void'(exp_q.pop_back());
          fence = idx + 1;
        end
      end
      if (in_valid && in_ready)
        exp_q.push_back(expected_commit(in_instr));
      hold_prev     = commit_valid && !commit_ready;
      rec_prev      = commit_rec;
      redirect_prev = redirect;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver tasks on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  // Mode 0 holds commit_ready low and mode 1 holds it high
  // Any other mode raises it 3 times in 4 at random
  task update_ready();
    case (ready_mode)
      0:       commit_ready = 1'b0;
      1:       commit_ready = 1'b1;
      default: commit_ready = (rand_bits(2) != 2'd0);
    endcase
  endtask

  task send_instr(input instr_t ins, input int max_cycles, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    @(negedge clock);
    update_ready();
    in_valid     = 1'b1;
    in_instr     = ins;
    in_instr.seq = seq_ctr;
    while (!ok && n < max_cycles) begin
      @(posedge clock);
      if (in_ready) begin
        ok = 1'b1;
      end else begin
        n++;
        if (n < max_cycles) begin
          @(negedge clock);
          update_ready();
        end
      end
    end
    if (ok)
      seq_ctr++;
  endtask

  task send_or_fail(input instr_t ins);
    bit ok;
    send_instr(ins, 500, ok);
    if (!ok) begin
      errors++;
      $display("ERROR t=%0t timeout, in_ready stayed low for 500 cycles", $time);
    end
  endtask

  task go_idle();
    @(negedge clock);
    update_ready();
    in_valid = 1'b0;
  endtask

  task drain_all();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 3000) begin
      @(negedge clock);
      update_ready();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR t=%0t timeout, %0d instructions never committed", $time, exp_q.size());
    end
  endtask

  task end_test(input int num, input string name);
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    test_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int     r0;
    int     tries;
    bit     ok;
    bit     stalled;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;

    reset        = 1'b1;
    in_valid     = 1'b0;
    in_instr     = '0;
    commit_ready = 1'b1;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Test 1 checks the idle outputs after reset
    assert (!commit_valid) else begin
      errors++;
      $display("ERROR t=%0t commit_valid expected 0 got %0b", $time, commit_valid);
    end
    assert (!redirect) else begin
      errors++;
      $display("ERROR t=%0t redirect expected 0 got %0b", $time, redirect);
    end
    assert (in_ready) else begin
      errors++;
      $display("ERROR t=%0t in_ready expected 1 got %0b", $time, in_ready);
    end
    end_test(1, "reset state");

    // Test 2 alternates slow and fast ops so younger ones finish first
    for (int i = 0; i < 12; i++)
      send_or_fail(make_instr(rand_bits(1) ? OP_SUB : OP_ADD, (i % 2 == 0) ? 2'd3 : 2'd0,
                              rand_bits(DATA_W), rand_bits(DATA_W), 1'b0));
    go_idle();
    drain_all();
    end_test(2, "add/sub in order");

    // Test 3 sends only correctly predicted branches
    r0 = redirects;
    for (int i = 0; i < 8; i++) begin
      a = rand_bits(DATA_W);
      b = rand_bits(1) ? a : rand_bits(DATA_W);
      send_or_fail(make_instr(OP_BRANCH, rand_bits(2), a, b, a == b));
    end
    go_idle();
    drain_all();
    assert (redirects == r0) else begin
      errors++;
      $display("ERROR t=%0t redirect raised for a correctly predicted branch", $time);
    end
    end_test(3, "predicted branches");

    // Test 4 puts a burst of younger adds behind a mispredicted branch
    r0 = redirects;
    send_or_fail(make_instr(OP_ADD, 2'd3, 16'd100, 16'd23, 1'b0));
    send_or_fail(make_instr(OP_BRANCH, 2'd3, 16'd5, 16'd5, 1'b0));
    for (int i = 0; i < 6; i++)
      send_or_fail(make_instr(OP_ADD, 2'd0, 16'(i), 16'd1000, 1'b0));
    go_idle();
    drain_all();
    for (int i = 0; i < 4; i++)
      send_or_fail(make_instr(OP_SUB, 2'(i), 16'd500, 16'(i), 1'b0));
    go_idle();
    drain_all();
    assert (redirects == r0 + 1) else begin
      errors++;
      $display("ERROR t=%0t expected one redirect for the mispredicted branch, saw %0d",
               $time, redirects - r0);
    end
    assert (dropped > 0) else begin
      errors++;
      $display("ERROR t=%0t no younger instruction was squashed by the redirect", $time);
    end
    end_test(4, "mispredict recovery");

    // Test 5 blocks the commit side until the input side stalls
    ready_mode = 0;
    stalled    = 1'b0;
    tries      = 0;
    while (!stalled && tries < 40) begin
      send_instr(make_instr(OP_ADD, rand_bits(2), rand_bits(DATA_W), rand_bits(DATA_W),
                            1'b0), 1, ok);
      stalled = !ok;
      tries++;
    end
    go_idle();
    assert (stalled) else begin
      errors++;
      $display("ERROR t=%0t in_ready never dropped with commit_ready held low", $time);
    end
    ready_mode = 1;
    drain_all();
    end_test(5, "back-pressure");

    // Test 6 runs a long random stream with random commit_ready
    ready_mode = 2;
    for (int i = 0; i < 200; i++)
      send_or_fail(random_instr());
    go_idle();
    drain_all();
    ready_mode = 1;
    // Settle so a stray extra commit would still be seen
    repeat (20) @(negedge clock);
    end_test(6, "random stream");

    $display("tests run: 6, errors: %0d, redirects: %0d", errors, redirects);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- flist.f
rtl/ooo_pkg.sv
rtl/sync_fifo.sv
rtl/dispatch.sv
rtl/exec_lane.sv
rtl/rob.sv
rtl/retire.sv
rtl/ooo_core_top.sv
tb/ooo_core_tb.sv
